//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_afu
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "Simulation passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- afu_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module afu_asserts (
  input wire                 clk,
  input wire                 resetb,
  input wire                 rd_req_valid,
  input wire afu_pkg::addr_t rd_req_addr,
  input wire                 rd_req_ready,
  input wire                 rd_rsp_valid,
  input wire                 wr_valid,
  input wire afu_pkg::addr_t wr_addr,
  input wire afu_pkg::word_t wr_data,
  input wire                 wr_ready
);

  logic [7:0] in_flight; // Reads accepted but not yet answered.

  always_ff @(posedge clk) begin
    if (!resetb) begin
      in_flight <= '0;
    end else begin
      in_flight <= in_flight + {7'd0, rd_req_valid && rd_req_ready} - {7'd0, rd_rsp_valid};
    end
  end

  rd_req_hold: assert property (@(posedge clk) disable iff (!resetb)
    rd_req_valid && !rd_req_ready |=> rd_req_valid && $stable(rd_req_addr))
    else $error("Read request dropped or changed while stalled.");

  wr_hold: assert property (@(posedge clk) disable iff (!resetb)
    wr_valid && !wr_ready |=> wr_valid && $stable(wr_addr) && $stable(wr_data))
    else $error("Write dropped or changed while stalled.");

  rsp_has_request: assert property (@(posedge clk) disable iff (!resetb)
    rd_rsp_valid |-> in_flight != 8'd0)
    else $error("Read response with no read outstanding.");

endmodule

bind afu_top afu_asserts u_asserts (.*);

`default_nettype wire

//--- afu_copy_engine.sv
`timescale 1ns/1ns
`default_nettype none
`include "afu_params.svh"

module afu_copy_engine (
  input wire                        clk,
  input wire                        resetb,
  afu_csr_if.engine                 csr,
  output logic                      rd_req_valid,
  output afu_pkg::addr_t            rd_req_addr,
  input wire                        rd_req_ready,
  input wire                        rd_rsp_valid,
  output logic                      wr_valid,
  output afu_pkg::addr_t            wr_addr,
  output afu_pkg::word_t            wr_data,
  input wire                        wr_ready,
  output logic                      fifo_push,
  output logic                      fifo_pop,
  input wire afu_pkg::word_t        fifo_data,
  input wire                        fifo_empty,
  input wire [`AFU_RSP_CNT_W-1:0]   fifo_count
);

  localparam int IDX_W = $clog2(`AFU_FRAME_WORDS + 1);
  localparam int CNT_W = `AFU_RSP_CNT_W;
  localparam logic [IDX_W-1:0] IDX_END  = IDX_W'(`AFU_FRAME_WORDS);
  localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(`AFU_FRAME_WORDS - 1);
  localparam logic [CNT_W:0]   RSV_LIM  = (CNT_W + 1)'(`AFU_RSP_DEPTH);

  afu_pkg::copy_state_t state;
  logic                 en_q;
  logic [IDX_W-1:0]     rd_idx;
  logic [IDX_W-1:0]     wr_idx;
  logic [CNT_W-1:0]     rd_outstanding;
  logic [CNT_W:0]       reserved;
  afu_pkg::word_t       checksum;
  logic                 start;
  logic                 rd_fire;
  logic                 wr_fire;

  // Rising edge of enable, taken only with both status bases programmed.
  assign start    = csr.afu_en && !en_q && csr.dsm_base_valid && csr.cntxt_base_valid;
  assign reserved = {1'b0, rd_outstanding} + {1'b0, fifo_count};
  assign rd_fire  = rd_req_valid && rd_req_ready;
  assign wr_fire  = wr_valid && wr_ready;

  // Every read in flight owns a FIFO slot, so responses never overflow.
  assign rd_req_valid = (state == afu_pkg::copy) && (rd_idx < IDX_END) && (reserved < RSV_LIM);
  assign rd_req_addr  = csr.read_frame + afu_pkg::addr_t'({rd_idx, 2'b00});

  assign fifo_push = rd_rsp_valid;
  assign fifo_pop  = (state == afu_pkg::copy) && wr_fire;

  always_comb begin
    wr_valid = 1'b0;
    wr_addr  = csr.write_frame + afu_pkg::addr_t'({wr_idx, 2'b00});
    wr_data  = fifo_data;
    case (state)
      afu_pkg::copy: wr_valid = !fifo_empty;
      afu_pkg::sum_write: begin
        wr_valid = 1'b1;
        wr_addr  = csr.cntxt_base;
        wr_data  = checksum;
      end
      afu_pkg::done_write: begin
        wr_valid = 1'b1;
        wr_addr  = csr.dsm_base;
        wr_data  = afu_pkg::word_t'(1); // Completion flag.
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!resetb) begin
      state          <= afu_pkg::idle;
      en_q           <= 1'b0;
      rd_idx         <= '0;
      wr_idx         <= '0;
      rd_outstanding <= '0;
    end else begin
      en_q <= csr.afu_en;
      if (rd_fire && !rd_rsp_valid) begin
        rd_outstanding <= rd_outstanding + 1'b1;
      end else if (!rd_fire && rd_rsp_valid) begin
        rd_outstanding <= rd_outstanding - 1'b1;
      end
      case (state)
        afu_pkg::idle: begin
          if (start) begin
            state  <= afu_pkg::copy;
            rd_idx <= '0;
            wr_idx <= '0;
          end
        end
        afu_pkg::copy: begin
          if (rd_fire) begin
            rd_idx <= rd_idx + 1'b1;
          end
          if (wr_fire) begin
            wr_idx <= wr_idx + 1'b1;
            if (wr_idx == IDX_LAST) begin
              state <= afu_pkg::sum_write; // Last data word accepted.
            end
          end
        end
        afu_pkg::sum_write: if (wr_fire) state <= afu_pkg::done_write;
        afu_pkg::done_write: if (wr_fire) state <= afu_pkg::idle;
        default: state <= afu_pkg::idle;
      endcase
    end
  end

  // Wrapping sum of the words as they leave for the write frame.
  always_ff @(posedge clk) begin
    if (state == afu_pkg::idle && start) begin
      checksum <= '0;
    end else if (fifo_pop) begin
      checksum <= checksum + fifo_data;
    end
  end

endmodule

`default_nettype wire

//--- afu_csr.sv
`timescale 1ns/1ns
`default_nettype none
`include "afu_params.svh"

module afu_csr (
  input wire                     clk,
  input wire                     resetb,
  input wire                     cfg_valid,
  input wire afu_pkg::csr_index_t cfg_index,
  input wire afu_pkg::word_t     cfg_data,
  afu_csr_if.csr                 csr
);

  logic [13:0] cfg_addr;

  assign cfg_addr = {cfg_index, 2'b00}; // Dword index to byte address.

  // Address registers load on a matching write and hold until rewritten.
  always_ff @(posedge clk) begin
    if (cfg_valid) begin
      case (cfg_addr)
        `ADDR_AFU_DSM_BASEL:     csr.dsm_base[31:0]     <= cfg_data;
        `ADDR_AFU_DSM_BASEH:     csr.dsm_base[63:32]    <= cfg_data;
        `ADDR_AFU_CNTXT_BASEL:   csr.cntxt_base[31:0]   <= cfg_data;
        `ADDR_AFU_CNTXT_BASEH:   csr.cntxt_base[63:32]  <= cfg_data;
        `ADDR_READ_FRAME_BASEL:  csr.read_frame[31:0]   <= cfg_data;
        `ADDR_READ_FRAME_BASEH:  csr.read_frame[63:32]  <= cfg_data;
        `ADDR_WRITE_FRAME_BASEL: csr.write_frame[31:0]  <= cfg_data;
        `ADDR_WRITE_FRAME_BASEH: csr.write_frame[63:32] <= cfg_data;
        default: ; // Unmapped addresses are dropped.
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!resetb) begin
      csr.dsm_base_valid   <= 1'b0;
      csr.cntxt_base_valid <= 1'b0;
      csr.afu_en           <= 1'b0;
    end else if (cfg_valid) begin
      if (cfg_addr == `ADDR_AFU_DSM_BASEL) begin
        csr.dsm_base_valid <= 1'b1; // Sticky until reset.
      end
      if (cfg_addr == `ADDR_AFU_CNTXT_BASEL) begin
        csr.cntxt_base_valid <= 1'b1;
      end
      if (cfg_addr == `ADDR_AFU_EN) begin
        csr.afu_en <= cfg_data[0]; // Only bit 0 is defined.
      end
    end
  end

endmodule

`default_nettype wire

//--- afu_csr_if.sv
`timescale 1ns/1ns
`default_nettype none

interface afu_csr_if;

  afu_pkg::addr_t dsm_base;
  logic           dsm_base_valid;
  afu_pkg::addr_t cntxt_base;
  logic           cntxt_base_valid;
  logic           afu_en;
  afu_pkg::addr_t read_frame;
  afu_pkg::addr_t write_frame;

  modport csr (
    output dsm_base, dsm_base_valid, cntxt_base, cntxt_base_valid,
    output afu_en, read_frame, write_frame
  );

  modport engine (
    input dsm_base, dsm_base_valid, cntxt_base, cntxt_base_valid,
    input afu_en, read_frame, write_frame
  );

endinterface

`default_nettype wire

//--- afu_params.svh
`ifndef AFU_PARAMS_SVH
`define AFU_PARAMS_SVH

// CSR byte addresses. A configuration write hits a register when its dword
// index shifted left by two equals the address.
`define ADDR_AFU_DSM_BASEL     14'h1a00
`define ADDR_AFU_DSM_BASEH     14'h1a04
`define ADDR_AFU_CNTXT_BASEL   14'h1a08
`define ADDR_AFU_CNTXT_BASEH   14'h1a0c
`define ADDR_AFU_EN            14'h1a10
`define ADDR_READ_FRAME_BASEL  14'h1a14
`define ADDR_READ_FRAME_BASEH  14'h1a18
`define ADDR_WRITE_FRAME_BASEL 14'h1a1c
`define ADDR_WRITE_FRAME_BASEH 14'h1a20

// Words moved by one copy.
`define AFU_FRAME_WORDS 16

// Response buffer depth, which also bounds the reads in flight.
`define AFU_RSP_DEPTH 4

// Width of an occupancy count that can hold 0 to AFU_RSP_DEPTH.
`define AFU_RSP_CNT_W $clog2(`AFU_RSP_DEPTH + 1)

`endif

//--- afu_pkg.sv
`default_nettype none

package afu_pkg;

  typedef logic [63:0] addr_t;      // Host byte address.
  typedef logic [31:0] word_t;      // Data word, CSR value or checksum.
  typedef logic [11:0] csr_index_t; // Dword index of a configuration write.

  typedef enum logic [1:0] {
    idle,
    copy,
    sum_write,
    done_write
  } copy_state_t;

endpackage

`default_nettype wire

//--- afu_top.sv
`timescale 1ns/1ns
`default_nettype none
`include "afu_params.svh"

module afu_top (
  input wire                      clk,
  input wire                      resetb,
  input wire                      cfg_valid,
  input wire afu_pkg::csr_index_t cfg_index,
  input wire afu_pkg::word_t      cfg_data,
  output logic                    rd_req_valid,
  output afu_pkg::addr_t          rd_req_addr,
  input wire                      rd_req_ready,
  input wire                      rd_rsp_valid,
  input wire afu_pkg::word_t      rd_rsp_data,
  output logic                    wr_valid,
  output afu_pkg::addr_t          wr_addr,
  output afu_pkg::word_t          wr_data,
  input wire                      wr_ready
);

  logic                      fifo_push;
  logic                      fifo_pop;
  afu_pkg::word_t            fifo_data;
  logic                      fifo_empty;
  logic [`AFU_RSP_CNT_W-1:0] fifo_count;

  afu_csr_if csr_bus ();

  afu_csr u_csr (
    .clk       (clk),
    .resetb    (resetb),
    .cfg_valid (cfg_valid),
    .cfg_index (cfg_index),
    .cfg_data  (cfg_data),
    .csr       (csr_bus.csr)
  );

  afu_copy_engine u_engine (
    .clk          (clk),
    .resetb       (resetb),
    .csr          (csr_bus.engine),
    .rd_req_valid (rd_req_valid),
    .rd_req_addr  (rd_req_addr),
    .rd_req_ready (rd_req_ready),
    .rd_rsp_valid (rd_rsp_valid),
    .wr_valid     (wr_valid),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .wr_ready     (wr_ready),
    .fifo_push    (fifo_push),
    .fifo_pop     (fifo_pop),
    .fifo_data    (fifo_data),
    .fifo_empty   (fifo_empty),
    .fifo_count   (fifo_count)
  );

  afu_word_fifo u_fifo (
    .clk       (clk),
    .resetb    (resetb),
    .push      (fifo_push),
    .push_data (rd_rsp_data), // Responses land here directly.
    .pop       (fifo_pop),
    .pop_data  (fifo_data),
    .empty     (fifo_empty),
    .count     (fifo_count)
  );

endmodule

`default_nettype wire

//--- afu_word_fifo.sv
`timescale 1ns/1ns
`default_nettype none
`include "afu_params.svh"

module afu_word_fifo (
  input wire                            clk,
  input wire                            resetb,
  input wire                            push,
  input wire afu_pkg::word_t            push_data,
  input wire                            pop,
  output afu_pkg::word_t                pop_data,
  output logic                          empty,
  output logic [`AFU_RSP_CNT_W-1:0]     count
);

  localparam int PTR_W = $clog2(`AFU_RSP_DEPTH);
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(`AFU_RSP_DEPTH - 1);
  localparam logic [`AFU_RSP_CNT_W-1:0] CNT_FULL = `AFU_RSP_CNT_W'(`AFU_RSP_DEPTH);

  afu_pkg::word_t   mem [`AFU_RSP_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             full;
  logic             do_push;
  logic             do_pop;

  assign empty    = (count == '0);
  assign full     = (count == CNT_FULL);
  assign do_push  = push && !full;
  assign do_pop   = pop && !empty;
  assign pop_data = mem[rd_ptr]; // Head word shows without a pop.

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetb) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- project.f
+incdir+.
afu_pkg.sv
afu_csr_if.sv
afu_csr.sv
afu_word_fifo.sv
afu_copy_engine.sv
afu_top.sv
afu_asserts.sv
tb_afu.sv

//--- tb_afu.sv
`timescale 1ns/1ns
`default_nettype none
`include "afu_params.svh"

module tb_afu;

  localparam int WRITES   = `AFU_FRAME_WORDS + 2;
  localparam int NUM_RUNS = 5;

  logic                clk;
  logic                resetb;
  logic                cfg_valid;
  afu_pkg::csr_index_t cfg_index;
  afu_pkg::word_t      cfg_data;
  logic                rd_req_valid;
  afu_pkg::addr_t      rd_req_addr;
  logic                rd_req_ready;
  logic                rd_rsp_valid;
  afu_pkg::word_t      rd_rsp_data;
  logic                wr_valid;
  afu_pkg::addr_t      wr_addr;
  afu_pkg::word_t      wr_data;
  logic                wr_ready;

  integer         seed = 32'hc847b470;
  int             errors = 0;
  int             checks = 0;
  int             stall_level = 0; // 0 none, 1 light, 2 heavy.
  int             expect_n = 0;
  int             wr_seen = 0;
  int             rd_seen = 0;
  afu_pkg::word_t mem_salt;
  afu_pkg::addr_t rd_base;
  afu_pkg::addr_t wr_base;
  afu_pkg::addr_t cx_base;
  afu_pkg::addr_t dsm_base;
  afu_pkg::addr_t exp_addr [$];
  afu_pkg::word_t exp_data [$];
  afu_pkg::addr_t pend_addr [$];
  int             pend_wait [$];

  afu_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic afu_pkg::word_t mem_word(input afu_pkg::addr_t addr);
    return addr[31:0] ^ (addr[63:32] * 32'h9e3779b1) ^ mem_salt;
  endfunction

  function automatic logic draw_ready();
    case (stall_level)
      0: return 1'b1;
      1: return ($random(seed) & 3) != 0;
      default: return ($random(seed) & 3) == 0;
    endcase
  endfunction

  function automatic int draw_delay();
    return (stall_level == 0) ? 0 : int'($unsigned($random(seed)) % 32'd4);
  endfunction

  // Data words in frame order, then the checksum, then the done flag.
  function automatic void build_expected();
    afu_pkg::word_t sum;
    int i;
    sum = '0;
    exp_addr.delete();
    exp_data.delete();
    for (i = 0; i < `AFU_FRAME_WORDS; i++) begin
      exp_addr.push_back(wr_base + 64'(4 * i));
      exp_data.push_back(mem_word(rd_base + 64'(4 * i)));
      sum = sum + exp_data[i];
    end
    exp_addr.push_back(cx_base);
    exp_data.push_back(sum);
    exp_addr.push_back(dsm_base);
    exp_data.push_back(32'd1);
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic apply_reset();
    @(negedge clk);
    resetb = 1'b0;
    repeat (3) @(negedge clk);
    resetb = 1'b1;
  endtask

  task automatic cfg_write(input logic [13:0] addr, input afu_pkg::word_t data);
    @(negedge clk);
    cfg_valid = 1'b1;
    cfg_index = addr[13:2];
    cfg_data  = data;
    @(negedge clk);
    cfg_valid = 1'b0;
  endtask

  task automatic program_bases(input logic with_dsm);
    if (with_dsm) begin
      cfg_write(`ADDR_AFU_DSM_BASEL, dsm_base[31:0]);
      cfg_write(`ADDR_AFU_DSM_BASEH, dsm_base[63:32]);
    end
    cfg_write(`ADDR_AFU_CNTXT_BASEL, cx_base[31:0]);
    cfg_write(`ADDR_AFU_CNTXT_BASEH, cx_base[63:32]);
    cfg_write(`ADDR_READ_FRAME_BASEL, rd_base[31:0]);
    cfg_write(`ADDR_READ_FRAME_BASEH, rd_base[63:32]);
    cfg_write(`ADDR_WRITE_FRAME_BASEL, wr_base[31:0]);
    cfg_write(`ADDR_WRITE_FRAME_BASEH, wr_base[63:32]);
  endtask

  task automatic run_copy();
    build_expected();
    wr_seen  = 0;
    rd_seen  = 0;
    expect_n = WRITES;
    cfg_write(`ADDR_AFU_EN, 32'd0);
    cfg_write(`ADDR_AFU_EN, 32'd1);
    wait (wr_seen == WRITES); // The done flag is the last write.
    repeat (10) @(negedge clk);
    if (rd_seen != `AFU_FRAME_WORDS) begin
      errors++;
      $display("Expected %0d read requests but saw %0d", `AFU_FRAME_WORDS, rd_seen);
    end
  endtask

  task automatic check_gated_start();
    logic busy;
    busy = 1'b0;
    repeat (60) begin
      @(negedge clk);
      busy = busy | rd_req_valid | wr_valid;
    end
    if (busy) begin
      errors++;
      $display("Copy started although the DSM base was never programmed");
    end
  endtask

  // Memory model. Responses return in order after 0 to 3 extra cycles.
  initial begin
    rd_req_ready = 1'b0;
    wr_ready     = 1'b0;
    rd_rsp_valid = 1'b0;
    rd_rsp_data  = '0;
    forever begin
      @(negedge clk);
      rd_req_ready = draw_ready();
      wr_ready     = draw_ready();
      rd_rsp_valid = 1'b0;
      if (pend_addr.size() > 0 && pend_wait[0] == 0) begin
        rd_rsp_valid = 1'b1;
        rd_rsp_data  = mem_word(pend_addr.pop_front());
        void'(pend_wait.pop_front());
      end
      foreach (pend_wait[i]) begin
        if (pend_wait[i] > 0) pend_wait[i]--;
      end
    end
  end

  always @(posedge clk) begin
    if (resetb && rd_req_valid && rd_req_ready) begin
      if (expect_n == 0 || rd_seen >= `AFU_FRAME_WORDS) begin
        errors++;
        $display("Read request to %h outside a copy", rd_req_addr);
      end else begin
        check_value("rd_req_addr", rd_base + 64'(4 * rd_seen), rd_req_addr);
      end
      rd_seen++;
      pend_addr.push_back(rd_req_addr);
      pend_wait.push_back(draw_delay());
    end
  end

  always @(posedge clk) begin
    if (resetb && wr_valid && wr_ready) begin
      if (wr_seen >= expect_n) begin
        errors++;
        $display("Unexpected write of %h to %h", wr_data, wr_addr);
      end else begin
        check_value("wr_addr", exp_addr[wr_seen], wr_addr);
        check_value("wr_data", {32'd0, exp_data[wr_seen]}, {32'd0, wr_data});
      end
      wr_seen++;
    end
  end

  // Each run is allowed 40 cycles per write.
  initial begin
    repeat (NUM_RUNS * WRITES * 40) @(posedge clk);
    $display("Timeout with %0d of %0d writes seen, the copy did not finish", wr_seen, expect_n);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    resetb    = 1'b0;
    cfg_valid = 1'b0;
    cfg_index = '0;
    cfg_data  = '0;
    mem_salt  = $random(seed);
    rd_base   = 64'h0000_0000_4000_0000;
    wr_base   = 64'h0000_0000_5000_0000;
    cx_base   = 64'h0000_0000_6000_0040;
    dsm_base  = 64'h0000_0000_7000_0000;
    apply_reset();
    program_bases(1'b1);
    run_copy();
    stall_level = 2;
    run_copy();
    apply_reset(); // The DSM valid flag clears here.
    stall_level = 1;
    program_bases(1'b0);
    expect_n = 0;
    cfg_write(`ADDR_AFU_EN, 32'd1);
    check_gated_start();
    cfg_write(`ADDR_AFU_DSM_BASEL, dsm_base[31:0]);
    cfg_write(`ADDR_AFU_DSM_BASEH, dsm_base[63:32]);
    run_copy();
    rd_base[63:32] = 32'h0000_0012;
    wr_base[63:32] = 32'h0000_0034;
    cfg_write(`ADDR_READ_FRAME_BASEH, rd_base[63:32]);
    cfg_write(`ADDR_WRITE_FRAME_BASEH, wr_base[63:32]);
    run_copy();
    cfg_write(14'h1a24, 32'hdead_beef);
    cfg_write(14'h0000, 32'h1234_5678);
    cfg_write(14'h3ffc, 32'hffff_ffff);
    run_copy();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
